//--- include/lsu_macros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Copy one field of the same name from a stage register into a pass struct
// Use inside a procedural block, e.g. `PASS(pass, req_q, rd);
`define PASS(dst, src, field) dst.field = src.field

`endif

//--- design/lsu_pkg.sv
package lsu_pkg;

    typedef logic [31:0] u32_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [1:0] {
        BYTE      = 2'd0,
        HALF_WORD = 2'd1,
        WORD      = 2'd2
    } size_t;

    // Memory operation as decoded by execute
    typedef struct packed {
        logic  is_mem;
        logic  is_store;
        logic  is_signed;
        size_t size;
    } mem_op_t;

    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_ALE  = 2'd1,
        EXC_ADE  = 2'd2
    } excp_code_t;

    typedef struct packed {
        logic       valid;
        excp_code_t code;
        u32_t       badv;
    } excp_t;

    // Request state handed from mem1 to mem2
    typedef struct packed {
        logic     valid;
        mem_op_t  op;
        reg_idx_t rd;
        u32_t     va;
        logic [1:0] offset;
    } mem1_mem2_pass_t;

    // Common operation encodings
    localparam mem_op_t OP_NOP = '{is_mem: 1'b0, is_store: 1'b0, is_signed: 1'b0, size: WORD};
    localparam mem_op_t OP_LB  = '{is_mem: 1'b1, is_store: 1'b0, is_signed: 1'b1, size: BYTE};
    localparam mem_op_t OP_LBU = '{is_mem: 1'b1, is_store: 1'b0, is_signed: 1'b0, size: BYTE};
    localparam mem_op_t OP_LH  = '{is_mem: 1'b1, is_store: 1'b0, is_signed: 1'b1, size: HALF_WORD};
    localparam mem_op_t OP_LHU = '{is_mem: 1'b1, is_store: 1'b0, is_signed: 1'b0, size: HALF_WORD};
    localparam mem_op_t OP_LW  = '{is_mem: 1'b1, is_store: 1'b0, is_signed: 1'b1, size: WORD};
    localparam mem_op_t OP_SB  = '{is_mem: 1'b1, is_store: 1'b1, is_signed: 1'b0, size: BYTE};
    localparam mem_op_t OP_SH  = '{is_mem: 1'b1, is_store: 1'b1, is_signed: 1'b0, size: HALF_WORD};
    localparam mem_op_t OP_SW  = '{is_mem: 1'b1, is_store: 1'b1, is_signed: 1'b0, size: WORD};

    // Data RAM geometry
    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = 8;

endpackage

//--- design/mmu_pkg.sv
package mmu_pkg;

    // Number of top address bits matched by a window
    localparam int SEG_W = 3;

    typedef logic [1:0] mat_t;

    // Strongly-ordered uncached and coherent cached
    localparam mat_t MAT_UNCACHED = 2'd0;
    localparam mat_t MAT_CACHED   = 2'd1;

    // Direct-mapped window
    typedef struct packed {
        logic             enable;
        logic [SEG_W-1:0] vseg;
        logic [SEG_W-1:0] pseg;
        mat_t             mat;
    } dmw_t;

    typedef struct packed {
        lsu_pkg::u32_t  pa;
        mat_t           mat;
        lsu_pkg::excp_t excp;
    } trans_res_t;

endpackage

//--- design/wb_if.sv
interface wb_if;

    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [3:0]  sel;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;

    modport master (
        output cyc, stb, we, adr, sel, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, sel, dat_w,
        output dat_r, ack
    );

endinterface

//--- design/addr_trans.sv
module addr_trans
    import lsu_pkg::*;
    import mmu_pkg::*;
(
    input  u32_t       va,
    input  size_t      size,
    input  logic       da_mode,
    input  dmw_t       dmw,
    output trans_res_t res
);

    logic misalign;
    logic in_window;

    assign misalign = (size == HALF_WORD && va[0]) ||
                      (size == WORD && va[1:0] != 2'b00);

    assign in_window = dmw.enable && (va[31:32-SEG_W] == dmw.vseg);

    always_comb begin
        res.pa         = va;
        res.mat        = MAT_CACHED;
        res.excp.valid = 1'b0;
        res.excp.code  = EXC_NONE;
        res.excp.badv  = va;

        // Mapped mode goes through the single window
        if (!da_mode) begin
            if (in_window) begin
                res.pa  = {dmw.pseg, va[31-SEG_W:0]};
                res.mat = dmw.mat;
            end else begin
                res.excp.valid = 1'b1;
                res.excp.code  = EXC_ADE;
            end
        end

        // Alignment fault wins over a window miss
        if (misalign) begin
            res.excp.valid = 1'b1;
            res.excp.code  = EXC_ALE;
        end
    end

endmodule

//--- design/mem1_stage.sv
`include "lsu_macros.svh"

module mem1_stage
    import lsu_pkg::*;
    import mmu_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic            in_valid,
    output logic            in_ready,
    input  mem_op_t         in_op,
    input  u32_t            in_va,
    input  u32_t            in_wdata,
    input  reg_idx_t        in_rd,
    input  logic            da_mode,
    input  dmw_t            dmw,
    wb_if.master            bus,
    output logic            m1_valid,
    input  logic            m2_ready,
    output mem1_mem2_pass_t pass,
    output excp_t           excp,
    output u32_t            bus_rdata
);

    // Translation mode travels with the request so the bus address stays put
    typedef struct packed {
        mem_op_t  op;
        u32_t     va;
        u32_t     wdata;
        reg_idx_t rd;
        logic     da_mode;
        dmw_t     dmw;
    } req_t;

    req_t       req_q;
    logic       valid_q;
    logic       dead_q;
    logic       cyc_q;
    logic       stb_q;
    trans_res_t tres;
    logic       use_bus;
    logic       bus_start;
    logic       bus_done;
    logic       m1_fire;
    logic [3:0] sel;
    u32_t       lanes;

    addr_trans u_addr_trans (
        .va      (req_q.va),
        .size    (req_q.op.size),
        .da_mode (req_q.da_mode),
        .dmw     (req_q.dmw),
        .res     (tres)
    );

    assign use_bus = req_q.op.is_mem & ~tres.excp.valid;

    // Only start when mem2 can take the ack, so a response is never lost
    assign bus_start = valid_q & use_bus & ~cyc_q & m2_ready & ~flush;
    assign bus_done  = cyc_q & bus.ack;

    assign m1_valid = valid_q & (use_bus ? bus_done : 1'b1);
    assign m1_fire  = m1_valid & m2_ready;
    assign in_ready = ~valid_q | m1_fire;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            dead_q  <= 1'b0;
        end else if (in_valid && in_ready) begin
            valid_q <= 1'b1;
            dead_q  <= 1'b0;
        end else if (m1_fire || (flush && !cyc_q)) begin
            valid_q <= 1'b0;
            dead_q  <= 1'b0;
        end else if (flush) begin
            // Cycle already on the bus, let it finish
            dead_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            req_q <= '{op: in_op, va: in_va, wdata: in_wdata, rd: in_rd,
                       da_mode: da_mode, dmw: dmw};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc_q <= 1'b0;
            stb_q <= 1'b0;
        end else if (bus_start) begin
            cyc_q <= 1'b1;
            stb_q <= 1'b1;
        end else if (bus_done) begin
            cyc_q <= 1'b0;
            stb_q <= 1'b0;
        end
    end

    // Byte enables and store data replicated across lanes
    always_comb begin
        case (req_q.op.size)
            BYTE: begin
                sel   = 4'b0001 << req_q.va[1:0];
                lanes = {4{req_q.wdata[7:0]}};
            end
            HALF_WORD: begin
                sel   = req_q.va[1] ? 4'b1100 : 4'b0011;
                lanes = {2{req_q.wdata[15:0]}};
            end
            default: begin
                sel   = 4'b1111;
                lanes = req_q.wdata;
            end
        endcase
    end

    assign bus.cyc   = cyc_q;
    assign bus.stb   = stb_q;
    assign bus.we    = req_q.op.is_store;
    assign bus.adr   = {tres.pa[31:2], 2'b00};
    assign bus.sel   = sel;
    assign bus.dat_w = lanes;

    always_comb begin
        pass.valid  = ~dead_q & ~flush;
        `PASS(pass, req_q, op);
        `PASS(pass, req_q, rd);
        `PASS(pass, req_q, va);
        pass.offset = req_q.va[1:0];
    end

    assign excp      = req_q.op.is_mem ? tres.excp : '0;
    assign bus_rdata = bus.dat_r;

    a_stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(bus.stb) |-> bus.cyc);

    a_master_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bus.stb && !bus.ack |=> bus.stb &&
            $stable({bus.we, bus.adr, bus.sel, bus.dat_w}));

    // mem2 must have room whenever the slave answers
    a_ack_has_room: assert property (@(posedge clk) disable iff (!rst_n)
        bus_done |-> m2_ready);

endmodule

//--- design/mem2_stage.sv
`include "lsu_macros.svh"

module mem2_stage
    import lsu_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic            m1_valid,
    output logic            m2_ready,
    input  mem1_mem2_pass_t pass,
    input  excp_t           excp,
    input  u32_t            bus_rdata,
    output logic            out_valid,
    input  logic            out_ready,
    output reg_idx_t        out_rd,
    output u32_t            out_data,
    output excp_t           out_excp
);

    typedef struct packed {
        reg_idx_t rd;
        u32_t     data;
        excp_t    excp;
    } m2_res_t;

    m2_res_t res_d;
    m2_res_t res_q;
    logic    out_valid_q;
    logic    m1_fire;
    u32_t    shifted;
    u32_t    load_data;

    assign m2_ready = ~out_valid_q | out_ready;
    assign m1_fire  = m1_valid & m2_ready;

    // Move the addressed byte or half-word down to bit 0
    assign shifted = bus_rdata >> {pass.offset, 3'b000};

    always_comb begin
        case (pass.op.size)
            BYTE: begin
                load_data = pass.op.is_signed ? {{24{shifted[7]}}, shifted[7:0]}
                                              : {24'd0, shifted[7:0]};
            end
            HALF_WORD: begin
                load_data = pass.op.is_signed ? {{16{shifted[15]}}, shifted[15:0]}
                                              : {16'd0, shifted[15:0]};
            end
            default: load_data = bus_rdata;
        endcase
    end

    always_comb begin
        `PASS(res_d, pass, rd);
        res_d.excp = excp;
        res_d.data = '0;
        // Stores and faulting accesses return zero
        if (!excp.valid && pass.op.is_mem && !pass.op.is_store) begin
            res_d.data = load_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
        end else if (flush) begin
            out_valid_q <= 1'b0;
        end else if (m1_fire) begin
            // Dead entries are consumed but never shown
            out_valid_q <= pass.valid;
        end else if (out_ready) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (m1_fire) begin
            res_q <= res_d;
        end
    end

    assign out_valid = out_valid_q;
    assign out_rd    = res_q.rd;
    assign out_data  = res_q.data;
    assign out_excp  = res_q.excp;

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready && !flush |=> out_valid && $stable(res_q));

endmodule

//--- design/wb_data_ram.sv
module wb_data_ram
    import lsu_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    wb_if.slave  bus
);

    u32_t              mem [RAM_WORDS];
    u32_t              rdata_q;
    logic              ack_q;
    logic              req;
    logic [RAM_AW-1:0] idx;

    assign idx = bus.adr[RAM_AW+1:2];

    // New request only, the master still holds stb during the ack cycle
    assign req = bus.cyc & bus.stb & ~ack_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            rdata_q <= mem[idx];
        end
        // Commit the write on the ack edge
        if (ack_q && bus.stb && bus.we) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.sel[i]) begin
                    mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
                end
            end
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = rdata_q;

    a_single_ack: assert property (@(posedge clk) disable iff (!rst_n)
        bus.ack |=> !bus.ack);

endmodule

//--- design/lsu_top.sv
module lsu_top
    import lsu_pkg::*;
    import mmu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     in_valid,
    output logic     in_ready,
    input  mem_op_t  in_op,
    input  u32_t     in_va,
    input  u32_t     in_wdata,
    input  reg_idx_t in_rd,
    input  logic     da_mode,
    input  dmw_t     dmw,
    output logic     out_valid,
    input  logic     out_ready,
    output reg_idx_t out_rd,
    output u32_t     out_data,
    output excp_t    out_excp
);

    logic            m1_valid;
    logic            m2_ready;
    mem1_mem2_pass_t pass;
    excp_t           excp;
    u32_t            bus_rdata;

    wb_if bus ();

    mem1_stage u_mem1 (
        .clk, .rst_n, .flush,
        .in_valid, .in_ready, .in_op, .in_va, .in_wdata, .in_rd,
        .da_mode, .dmw,
        .bus       (bus.master),
        .m1_valid, .m2_ready, .pass, .excp, .bus_rdata
    );

    mem2_stage u_mem2 (
        .clk, .rst_n, .flush,
        .m1_valid, .m2_ready, .pass, .excp, .bus_rdata,
        .out_valid, .out_ready, .out_rd, .out_data, .out_excp
    );

    wb_data_ram u_ram (
        .clk,
        .rst_n,
        .bus (bus.slave)
    );

endmodule

//--- test/lsu_tb.sv
module lsu_tb
    import lsu_pkg::*;
    import mmu_pkg::*;
();

    typedef struct packed {
        logic [2:0] grp;
        mem_op_t    op;
        u32_t       va;
        u32_t       wdata;
        reg_idx_t   rd;
        logic       da;
        dmw_t       dmw;
        logic       stall;
        logic       flush;
        u32_t       exp_data;
        excp_code_t exp_code;
    } row_t;

    // Window maps virtual segment 101 onto physical segment 000
    localparam dmw_t WIN   = '{enable: 1'b1, vseg: 3'b101, pseg: 3'b000, mat: MAT_CACHED};
    localparam dmw_t NOWIN = '{enable: 1'b0, vseg: 3'b101, pseg: 3'b000, mat: MAT_CACHED};

    localparam int NROWS = 38;

    // grp, op, va, wdata, rd, da_mode, dmw, stall, flush, expected data, expected code
    localparam row_t TBL [NROWS] = '{
        '{3'd1, OP_SW,  32'h100, 32'hdeadbeef, 5'd1, 1'b1, NOWIN, 1'b0, 1'b0, 32'h0, EXC_NONE},
        '{3'd1, OP_LW,  32'h100, 32'h0, 5'd2, 1'b1, NOWIN, 1'b0, 1'b0, 32'hdeadbeef, EXC_NONE},
        '{3'd2, OP_SW,  32'h104, 32'h0, 5'd3, 1'b1, NOWIN, 1'b0, 1'b0, 32'h0, EXC_NONE},
        '{3'd2, OP_SB,  32'h104, 32'h11, 5'd4, 1'b1, NOWIN, 1'b0, 1'b0, 32'h0, EXC_NONE},
        '{3'd2, OP_SB,  32'h105, 32'h555555a2, 5'd5, 1'b1, NOWIN, 1'b0, 1'b0, 32'h0, EXC_NONE},
        '{3'd2, OP_SB,  32'h106, 32'h33, 5'd6, 1'b1, NOWIN, 1'b0, 1'b0, 32'h0, EXC_NONE},
        '{3'd2, OP_SB,  32'h107, 32'hc4, 5'd7, 1'b1, NOWIN, 1'b0, 1'b0, 32'h0, EXC_NONE},
        '{3'd2, OP_LW,  32'h104, 32'h0, 5'd8, 1'b1, NOWIN, 1'b0, 1'b0, 32'hc433a211, EXC_NONE},
        '{3'd2, OP_LB,  32'h105, 32'h0, 5'd9, 1'b1, NOWIN, 1'b0, 1'b0, 32'hffffffa2, EXC_NONE},
        '{3'd2, OP_LBU, 32'h107, 32'h0, 5'd10, 1'b1, NOWIN, 1'b0, 1'b0, 32'h000000c4, EXC_NONE},
        '{3'd2, OP_LB,  32'h104, 32'h0, 5'd11, 1'b1, NOWIN, 1'b0, 1'b0, 32'h00000011, EXC_NONE},
        '{3'd2, OP_SW,  32'h108, 32'h01234567, 5'd12, 1'b1, NOWIN, 1'b0, 1'b0, 32'h0, EXC_NONE},
        '{3'd2, OP_SH,  32'h108, 32'hbeef, 5'd13, 1'b1, NOWIN, 1'b0, 1'b0, 32'h0, EXC_NONE},
        '{3'd2, OP_SH,  32'h10a, 32'h8001, 5'd14, 1'b1, NOWIN, 1'b0, 1'b0, 32'h0, EXC_NONE},
        '{3'd2, OP_LH,  32'h108, 32'h0, 5'd15, 1'b1, NOWIN, 1'b0, 1'b0, 32'hffffbeef, EXC_NONE},
        '{3'd2, OP_LHU, 32'h10a, 32'h0, 5'd16, 1'b1, NOWIN, 1'b0, 1'b0, 32'h00008001, EXC_NONE},
        '{3'd2, OP_LH,  32'h10a, 32'h0, 5'd17, 1'b1, NOWIN, 1'b0, 1'b0, 32'hffff8001, EXC_NONE},
        '{3'd3, OP_SH,  32'h109, 32'hffff, 5'd18, 1'b1, NOWIN, 1'b0, 1'b0, 32'h0, EXC_ALE},
        '{3'd3, OP_SW,  32'h10a, 32'hffffffff, 5'd19, 1'b1, NOWIN, 1'b0, 1'b0, 32'h0, EXC_ALE},
        '{3'd3, OP_LW,  32'h101, 32'h0, 5'd20, 1'b1, NOWIN, 1'b0, 1'b0, 32'h0, EXC_ALE},
        '{3'd3, OP_LW,  32'h108, 32'h0, 5'd21, 1'b1, NOWIN, 1'b0, 1'b0, 32'h8001beef, EXC_NONE},
        '{3'd4, OP_SW,  32'ha0000040, 32'h5a5ac3c3, 5'd22, 1'b0, WIN, 1'b0, 1'b0, 32'h0, EXC_NONE},
        '{3'd4, OP_LW,  32'h40, 32'h0, 5'd23, 1'b1, NOWIN, 1'b0, 1'b0, 32'h5a5ac3c3, EXC_NONE},
        '{3'd4, OP_LW,  32'ha0000040, 32'h0, 5'd24, 1'b0, WIN, 1'b0, 1'b0, 32'h5a5ac3c3, EXC_NONE},
        '{3'd4, OP_SW,  32'h20000044, 32'h12345678, 5'd25, 1'b0, WIN, 1'b0, 1'b0, 32'h0, EXC_ADE},
        '{3'd4, OP_LW,  32'ha0000040, 32'h0, 5'd26, 1'b0, NOWIN, 1'b0, 1'b0, 32'h0, EXC_ADE},
        '{3'd4, OP_LW,  32'h20000046, 32'h0, 5'd27, 1'b0, WIN, 1'b0, 1'b0, 32'h0, EXC_ALE},
        '{3'd5, OP_SW,  32'h200, 32'h11112222, 5'd28, 1'b1, NOWIN, 1'b1, 1'b0, 32'h0, EXC_NONE},
        '{3'd5, OP_SW,  32'h204, 32'h33334444, 5'd29, 1'b1, NOWIN, 1'b1, 1'b0, 32'h0, EXC_NONE},
        '{3'd5, OP_LW,  32'h200, 32'h0, 5'd30, 1'b1, NOWIN, 1'b1, 1'b0, 32'h11112222, EXC_NONE},
        '{3'd5, OP_SB,  32'h206, 32'h99, 5'd31, 1'b1, NOWIN, 1'b1, 1'b0, 32'h0, EXC_NONE},
        '{3'd5, OP_LW,  32'h204, 32'h0, 5'd1, 1'b1, NOWIN, 1'b1, 1'b0, 32'h33994444, EXC_NONE},
        '{3'd5, OP_LHU, 32'h206, 32'h0, 5'd2, 1'b1, NOWIN, 1'b1, 1'b0, 32'h00003399, EXC_NONE},
        '{3'd5, OP_LB,  32'h200, 32'h0, 5'd3, 1'b1, NOWIN, 1'b1, 1'b0, 32'h00000022, EXC_NONE},
        '{3'd5, OP_LW,  32'h100, 32'h0, 5'd4, 1'b1, NOWIN, 1'b1, 1'b0, 32'hdeadbeef, EXC_NONE},
        '{3'd6, OP_SW,  32'h300, 32'h600dcafe, 5'd5, 1'b1, NOWIN, 1'b0, 1'b0, 32'h0, EXC_NONE},
        '{3'd6, OP_SW,  32'h300, 32'h0badf00d, 5'd6, 1'b1, NOWIN, 1'b0, 1'b1, 32'h0, EXC_NONE},
        '{3'd6, OP_LW,  32'h300, 32'h0, 5'd7, 1'b1, NOWIN, 1'b0, 1'b0, 32'h600dcafe, EXC_NONE}
    };

    string grp_name [6] = '{"word store and load", "byte and half-word merge",
                            "misaligned access", "mapped window", "random stalls", "flush"};

    logic     clk;
    logic     rst_n;
    logic     flush;
    logic     in_valid;
    logic     in_ready;
    mem_op_t  in_op;
    u32_t     in_va;
    u32_t     in_wdata;
    reg_idx_t in_rd;
    logic     da_mode;
    dmw_t     dmw;
    logic     out_valid;
    logic     out_ready;
    reg_idx_t out_rd;
    u32_t     out_data;
    excp_t    out_excp;

    int          pend_q [$];
    int          n_checked = 0;
    int          n_err = 0;
    logic        stall_mode = 1'b0;
    logic [31:0] rng = 32'd40;

    lsu_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_output(input int idx);
        row_t r;
        logic exp_valid;
        r = TBL[idx];
        exp_valid = (r.exp_code != EXC_NONE);
        n_checked++;
        if (out_rd !== r.rd) begin
            $display("FAIL @%0t: row %0d rd is %0d, expected %0d", $time, idx, out_rd, r.rd);
            n_err++;
        end
        if (out_data !== r.exp_data) begin
            $display("FAIL @%0t: row %0d data is %h, expected %h",
                     $time, idx, out_data, r.exp_data);
            n_err++;
        end
        if (out_excp.valid !== exp_valid || out_excp.code !== r.exp_code) begin
            $display("FAIL @%0t: row %0d exception %b/%0d, expected code %0d",
                     $time, idx, out_excp.valid, out_excp.code, r.exp_code);
            n_err++;
        end
        if (exp_valid && out_excp.badv !== r.va) begin
            $display("FAIL @%0t: row %0d badv is %h, expected %h",
                     $time, idx, out_excp.badv, r.va);
            n_err++;
        end
    endtask

    // Let every outstanding result leave mem2 before going on
    task automatic wait_outputs_drained();
        @(negedge clk);
        in_valid = 1'b0;
        while (pend_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
    endtask

    // Output side: back-pressure and in-order compare
    initial begin : monitor
        int idx;
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (stall_mode) begin
                rng = xorshift32(rng);
                out_ready = rng[3];
            end else begin
                out_ready = 1'b1;
            end
            if (out_valid === 1'b1 && out_ready) begin
                if (pend_q.size() == 0) begin
                    $display("unexpected output at time %0t with no request outstanding", $time);
                    n_err++;
                end else begin
                    idx = pend_q.pop_front();
                    check_output(idx);
                end
            end
        end
    end

    initial begin : watchdog
        repeat (NROWS * 20 + 50) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", NROWS * 20 + 50);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : driver
        row_t r;
        logic last;
        int   chk0;
        int   err0;
        rst_n    = 1'b0;
        flush    = 1'b0;
        in_valid = 1'b0;
        in_op    = OP_NOP;
        in_va    = '0;
        in_wdata = '0;
        in_rd    = '0;
        da_mode  = 1'b1;
        dmw      = '0;
        chk0     = 0;
        err0     = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < NROWS; i++) begin
            r = TBL[i];
            // Flush must only hit the request it targets
            if (r.flush) begin
                wait_outputs_drained();
            end
            @(negedge clk);
            in_valid = 1'b1;
            in_op    = r.op;
            in_va    = r.va;
            in_wdata = r.wdata;
            in_rd    = r.rd;
            da_mode  = r.da;
            dmw      = r.dmw;
            do begin
                @(posedge clk);
            end while (in_ready !== 1'b1);
            stall_mode = r.stall;
            if (!r.flush) begin
                pend_q.push_back(i);
            end else begin
                @(negedge clk);
                in_valid = 1'b0;
                flush    = 1'b1;
                @(negedge clk);
                flush = 1'b0;
            end

            last = (i == NROWS - 1) ? 1'b1 : (TBL[i + 1].grp != r.grp);
            if (last) begin
                wait_outputs_drained();
                $display("test %0d (%s): %0d outputs checked, %0d errors", r.grp,
                         grp_name[r.grp - 1], n_checked - chk0, n_err - err0);
                chk0 = n_checked;
                err0 = n_err;
            end
        end

        $display("%0d outputs checked, %0d errors", n_checked, n_err);
        if (n_err == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- lsu_top.f
+incdir+include
design/lsu_pkg.sv
design/mmu_pkg.sv
design/wb_if.sv
design/addr_trans.sv
design/mem1_stage.sv
design/mem2_stage.sv
design/wb_data_ram.sv
design/lsu_top.sv
test/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu_top

export_include_dirs:
  - include

sources:
  - design/lsu_pkg.sv
  - design/mmu_pkg.sv
  - design/wb_if.sv
  - design/addr_trans.sv
  - design/mem1_stage.sv
  - design/mem2_stage.sv
  - design/wb_data_ram.sv
  - design/lsu_top.sv
  - target: simulation
    files:
      - test/lsu_tb.sv
